//--- wb_flash_trace.txt
# kind  wb word address (hex)  cti (hex)  expected data (hex)  latency (0 = not checked)
# kinds RD classic read, BST 4 beat burst, WR write, OUT foreign region, RND random read
RD  3F800010 0 a5b50010 0
RD  3F800011 0 a5b40011 1
RD  3F800013 0 a5b60013 1
RD  3F801236 0 b7931236 0
RD  3F801237 0 b7921237 1
BST 3F800020 2 a5850020 0
BST 3F800020 2 a5850020 1
WR  3F800030 0 00000000 1
RD  3F800030 0 a5950030 0
RD  3F800030 0 a5950030 1
OUT 00000040 0 00000000 1
OUT 1F800040 0 00000000 1
RD  3F800110 0 a4b50110 0
RD  3F800012 0 a5b70012 0
RND 0 0 0 0
RND 0 0 0 0
RND 0 0 0 0
RND 0 0 0 0
RND 0 0 0 0
RND 0 0 0 0

//--- wb_flash_sword.f
+incdir+.
flash_wb_pkg.sv
flash_core.sv
wb_mem_adapter.sv
wb_flash_sword.sv
tb_flash_model.sv
tb_wb_flash_sword.sv

//--- Bender.yml
package:
  name: wb_flash_sword

export_include_dirs:
  - .

sources:
  - files:
      - flash_wb_pkg.sv
      - flash_core.sv
      - wb_mem_adapter.sv
      - wb_flash_sword.sv
  - target: test
    files:
      - tb_flash_model.sv
      - tb_wb_flash_sword.sv

//--- tb_wb_flash_sword.sv
`timescale 1ns/1ps

module tb_wb_flash_sword;
	import flash_wb_pkg::*;

	localparam int CLK_MHZ = 250;  // 4 ns period
	localparam int MAX_REC = 64;

	logic clk = 1'b0;
	logic rst_n;
	wb_req_t wb;
	logic busy;
	flash_pins_t pins;
	logic [1:0] ready;
	word_addr_t faddr;
	word_t fdata;
	word_t rdata;
	logic ack;

	string rec_kind [MAX_REC];
	wb_addr_t rec_addr [MAX_REC];
	logic [2:0] rec_cti [MAX_REC];
	word_t rec_exp [MAX_REC];
	int rec_lat [MAX_REC];
	int n_rec;
	int cycles;
	int limit;
	logic [31:0] lcg;
	logic ce_seen;
	logic ready_seen;

	always #2 clk = ~clk;

	wb_flash_sword #(.CLK_FREQ(CLK_MHZ)) u_wb_flash_sword (
		.clk(clk),
		.rst_n_i(rst_n),
		.flash_busy_o(busy),
		.flash_pins_o(pins),
		.flash_ready_i(ready),
		.flash_addr_o(faddr),
		.flash_din_i(fdata),
		.wb_i(wb),
		.wbs_data_o(rdata),
		.wbs_ack_o(ack)
	);

	tb_flash_model u_flash (
		.clk(clk),
		.flash_rst_n_i(pins.rst_n),
		.addr_i(faddr),
		.data_o(fdata),
		.ready_o(ready)
	);

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (pins.ce_n != 2'b11)
			ce_seen <= 1'b1;
		if (&ready)
			ready_seen <= 1'b1;
		if (limit > 0 && cycles >= limit) begin
			$display("timeout: run did not finish within %0d cycles", limit);
			stop_run();
		end
	end

	task automatic stop_run();
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			$display("FAIL %s expected %h actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAIL %s expected %b actual %b", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_latency(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("FAIL %s expected %0d actual %0d", name, exp, act);
			stop_run();
		end
	endtask

	function automatic word_t expected_flash_word(input word_addr_t a);
		return {a[15:0] ^ 16'hA5A5, a[15:0]};
	endfunction

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic load_trace();
		int fd;
		int n;
		string line;
		string k;
		logic [31:0] a;
		logic [31:0] c;
		logic [31:0] e;
		int l;
		fd = $fopen("wb_flash_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file wb_flash_trace.txt");
			stop_run();
		end
		n_rec = 0;
		while (!$feof(fd) && $fgets(line, fd) > 0) begin
			if (line.len() > 1 && line[0] != 8'h23) begin  // skip comments and blanks
				n = $sscanf(line, "%s %h %h %h %d", k, a, c, e, l);
				if (n != 5 || n_rec >= MAX_REC) begin
					$display("malformed or extra trace line: %s", line);
					stop_run();
				end
				rec_kind[n_rec] = k;
				rec_addr[n_rec] = a[29:0];
				rec_cti[n_rec] = c[2:0];
				rec_exp[n_rec] = e;
				rec_lat[n_rec] = l;
				n_rec++;
			end
		end
		$fclose(fd);
	endtask

	// starts right after a rising edge and returns at the ack edge
	task automatic wb_access(input wb_addr_t a, input logic we, input logic [2:0] cti,
			output word_t d, output int lat);
		wb.cyc <= 1'b1;
		wb.stb <= 1'b1;
		wb.we <= we;
		wb.cti <= cti;
		wb.bte <= 2'b00;
		wb.addr <= a;
		lat = -1;  // edge where the DUT first sees stb
		do begin
			@(posedge clk);
			lat++;
		end while (!ack);
		d = rdata;
	endtask

	task automatic end_cycle();
		wb.cyc <= 1'b0;
		wb.stb <= 1'b0;
		wb.we <= 1'b0;
		wb.cti <= 3'b000;
		@(posedge clk);
	endtask

	task automatic wait_idle();
		while (busy)
			@(posedge clk);
	endtask

	task automatic run_record(input int i);
		string name;
		string k;
		wb_addr_t a;
		word_t d;
		word_t e;
		int lat;
		k = rec_kind[i];
		a = rec_addr[i];
		e = rec_exp[i];
		name = $sformatf("%0d_%s_%h", i, k, a);
		wait_idle();
		if (k == "RND") begin
			lcg = lcg_next(lcg);
			a = {7'h7F, lcg[30:8]};
			name = $sformatf("%0d_RND_%h", i, a);
			wb_access(a, 1'b0, 3'b000, d, lat);
			end_cycle();
			check_word(name, expected_flash_word(a[22:0]), d);
		end else if (k == "RD") begin
			wb_access(a, 1'b0, rec_cti[i], d, lat);
			end_cycle();
			check_word(name, e, d);
			if (rec_lat[i] > 0)
				check_latency(name, rec_lat[i], lat);
		end else if (k == "WR") begin
			wb_access(a, 1'b1, 3'b000, d, lat);
			end_cycle();
			check_latency(name, rec_lat[i], lat);
		end else if (k == "OUT") begin
			ce_seen = 1'b0;
			wb_access(a, 1'b0, 3'b000, d, lat);
			end_cycle();
			check_word(name, e, d);
			check_latency(name, rec_lat[i], lat);
			wait_idle();
			check_bit({name, "_ce"}, 1'b0, ce_seen);
		end else if (k == "BST") begin
			for (int b = 0; b < 4; b++) begin
				wb_access(a + b, 1'b0, (b == 3) ? 3'b111 : rec_cti[i], d, lat);
				check_word($sformatf("%s_beat%0d", name, b),
					(b == 0) ? e : expected_flash_word(a[22:0] + b), d);
				if (b > 0 && rec_lat[i] > 0)
					check_latency($sformatf("%s_beat%0d", name, b), rec_lat[i], lat);
			end
			end_cycle();
		end else begin
			$display("unknown record kind %s in the trace", k);
			stop_run();
		end
	endtask

	initial begin
		rst_n = 1'b0;
		wb = '0;
		ce_seen = 1'b0;
		ready_seen = 1'b0;
		cycles = 0;
		limit = 0;
		lcg = 32'h5a7b;
		load_trace();
		limit = n_rec * 200 + 500;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		check_bit("reset_busy", 1'b1, busy);
		check_bit("reset_ce_n0", 1'b1, pins.ce_n[0]);
		check_bit("reset_ce_n1", 1'b1, pins.ce_n[1]);
		check_bit("reset_oe_n", 1'b1, pins.oe_n);
		check_bit("reset_chip_rst_n", 1'b0, pins.rst_n);
		check_bit("reset_we_n", 1'b1, pins.we_n);
		check_bit("reset_wp_n", 1'b0, pins.wp_n);
		wait_idle();
		check_bit("busy_after_ready", 1'b1, ready_seen);
		for (int i = 0; i < n_rec; i++)
			run_record(i);
		$display("Done: no errors");
		$finish;
	end

endmodule

//--- tb_flash_model.sv
`timescale 1ns/1ps

module tb_flash_model #(
	parameter real ACC_DLY_NS = 99.5,   // settles just inside the 100 ns access time
	parameter real PAGE_DLY_NS = 24.5,  // and inside the 25 ns page time
	parameter int READY_CYC = 10
) (
	input  logic clk,
	input  logic flash_rst_n_i,
	input  flash_wb_pkg::word_addr_t addr_i,
	output flash_wb_pkg::word_t data_o,
	output logic [1:0] ready_o
);
	import flash_wb_pkg::*;

	logic [20:0] last_line;  // page of the previous address
	int ready_cnt;

	// chip 1 in the high half, chip 0 in the low half
	function automatic word_t cell_value(input word_addr_t a);
		return {a[15:0] ^ 16'hA5A5, a[15:0]};
	endfunction

	initial begin
		data_o = '0;
		ready_o = 2'b00;
		ready_cnt = 0;
		last_line = '1;
	end

	always @(addr_i) begin
		data_o <= 'x;  // output invalid while the array is read
		if (addr_i[22:2] == last_line)
			data_o <= #(PAGE_DLY_NS) cell_value(addr_i);
		else
			data_o <= #(ACC_DLY_NS) cell_value(addr_i);
		last_line = addr_i[22:2];
	end

	always @(posedge clk or negedge flash_rst_n_i) begin
		if (!flash_rst_n_i) begin
			ready_cnt <= 0;
			ready_o <= 2'b00;
		end else if (ready_cnt < READY_CYC) begin
			ready_cnt <= ready_cnt + 1;
		end else begin
			ready_o <= 2'b11;  // both chips out of internal reset
		end
	end

endmodule

//--- wb_flash_sword.sv
`timescale 1ns/1ps
`include "flash_wb_defines.svh"

module wb_flash_sword #(
	parameter int CLK_FREQ = `FLASH_CLK_FREQ  // MHz
) (
	input  logic clk,
	input  logic rst_n_i,
	output logic flash_busy_o,
	output flash_wb_pkg::flash_pins_t flash_pins_o,
	input  logic [1:0] flash_ready_i,
	output flash_wb_pkg::word_addr_t flash_addr_o,
	input  flash_wb_pkg::word_t flash_din_i,
	input  flash_wb_pkg::wb_req_t wb_i,
	output flash_wb_pkg::word_t wbs_data_o,
	output logic wbs_ack_o
);
	import flash_wb_pkg::*;

	mem_req_t mem_req;
	word_t mem_dout;
	logic core_ack;
	logic core_busy;
	logic adapter_busy;
	logic ready_all;
	logic [1:0] ce_n;
	logic chip_rst_n;
	logic oe_n;
	logic we_n;
	logic wp_n;

	assign ready_all = &flash_ready_i;  // both chips

	// low half, also drives the shared pins
	flash_core #(
		.CLK_FREQ(CLK_FREQ),
		.ADDR_BITS(`FLASH_ADDR_BITS),
		.T_ACC_NS(`FLASH_T_ACC_NS),
		.T_PAGE_NS(`FLASH_T_PAGE_NS)
	) u_core0 (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.req_i(mem_req),
		.dout_o(mem_dout[15:0]),
		.ack_o(core_ack),
		.busy_o(core_busy),
		.flash_ce_n_o(ce_n[0]),
		.flash_rst_n_o(chip_rst_n),
		.flash_oe_n_o(oe_n),
		.flash_we_n_o(we_n),
		.flash_wp_n_o(wp_n),
		.flash_ready_i(ready_all),
		.flash_addr_o(flash_addr_o),
		.flash_din_i(flash_din_i[15:0])
	);

	// high half, runs in lock step with core 0
	flash_core #(
		.CLK_FREQ(CLK_FREQ),
		.ADDR_BITS(`FLASH_ADDR_BITS),
		.T_ACC_NS(`FLASH_T_ACC_NS),
		.T_PAGE_NS(`FLASH_T_PAGE_NS)
	) u_core1 (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.req_i(mem_req),
		.dout_o(mem_dout[31:16]),
		.ack_o(),
		.busy_o(),
		.flash_ce_n_o(ce_n[1]),
		.flash_rst_n_o(),
		.flash_oe_n_o(),
		.flash_we_n_o(),
		.flash_wp_n_o(),
		.flash_ready_i(ready_all),
		.flash_addr_o(),
		.flash_din_i(flash_din_i[31:16])
	);

	wb_mem_adapter #(
		.ADDR_BITS(`FLASH_ADDR_BITS),
		.HIGH_ADDR(`FLASH_HIGH_ADDR),
		.BURST_BITS(`FLASH_BURST_BITS),
		.BUF_BITS(`FLASH_BUF_BITS)
	) u_adapter (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.wb_i(wb_i),
		.wbs_data_o(wbs_data_o),
		.wbs_ack_o(wbs_ack_o),
		.busy_o(adapter_busy),
		.mem_req_o(mem_req),
		.mem_dout_i(mem_dout),
		.mem_ack_i(core_ack),
		.mem_busy_i(core_busy)
	);

	assign flash_pins_o = '{ce_n: ce_n, rst_n: chip_rst_n, oe_n: oe_n, we_n: we_n, wp_n: wp_n};
	assign flash_busy_o = adapter_busy | core_busy;

endmodule

//--- wb_mem_adapter.sv
`timescale 1ns/1ps
`include "flash_wb_defines.svh"

module wb_mem_adapter #(
	parameter int ADDR_BITS = `FLASH_ADDR_BITS,
	parameter logic [31-ADDR_BITS:0] HIGH_ADDR = `FLASH_HIGH_ADDR,
	parameter int BURST_BITS = `FLASH_BURST_BITS,
	parameter int BUF_BITS = `FLASH_BUF_BITS
) (
	input  logic clk,
	input  logic rst_n_i,
	input  flash_wb_pkg::wb_req_t wb_i,
	output flash_wb_pkg::word_t wbs_data_o,
	output logic wbs_ack_o,
	output logic busy_o,
	output flash_wb_pkg::mem_req_t mem_req_o,
	input  flash_wb_pkg::word_t mem_dout_i,
	input  logic mem_ack_i,
	input  logic mem_busy_i
);
	import flash_wb_pkg::*;

	localparam int OFS_W = BURST_BITS - 2;          // word within a line
	localparam int IDX_W = BUF_BITS - OFS_W;        // line within the buffer
	localparam int TAG_W = ADDR_BITS - 2 - BUF_BITS;
	localparam int LINE_W = ADDR_BITS - 2 - OFS_W;  // line number on the device
	localparam int LINES = 1 << IDX_W;
	localparam int WORDS = 1 << BUF_BITS;

	fill_state_e state_q;
	word_t buf_mem [WORDS];
	logic [TAG_W-1:0] tag_q [LINES];
	logic [LINES-1:0] valid_q;

	word_addr_t req_waddr;
	logic [OFS_W-1:0] req_ofs;
	logic [IDX_W-1:0] req_idx;
	logic [TAG_W-1:0] req_tag;
	logic in_region;
	logic req_new;
	logic bypass;
	logic rd_req;
	logic hit;
	logic buf_serve;
	logic fill_start;
	logic fill_word;
	logic fill_hit;

	logic [LINE_W-1:0] fill_line_q;
	logic [OFS_W-1:0] fill_ofs_q;
	logic [IDX_W-1:0] fill_idx;
	logic cs_q;
	logic burst_q;
	logic ack_q;
	word_t data_q;

	assign req_waddr = wb_i.addr[ADDR_BITS-3:0];
	assign req_ofs = req_waddr[OFS_W-1:0];
	assign req_idx = req_waddr[BUF_BITS-1:OFS_W];
	assign req_tag = req_waddr[ADDR_BITS-3:BUF_BITS];
	assign in_region = (wb_i.addr[29:ADDR_BITS-2] == HIGH_ADDR);

	// a held stb is answered once
	assign req_new = wb_i.cyc && wb_i.stb && !ack_q;
	assign bypass = req_new && (wb_i.we || !in_region);  // writes and foreign reads
	assign rd_req = req_new && !wb_i.we && in_region;
	assign hit = valid_q[req_idx] && (tag_q[req_idx] == req_tag);

	assign buf_serve = (state_q != F_FILL) && rd_req && hit;
	assign fill_start = (state_q == F_IDLE) && rd_req && !hit && !mem_busy_i;
	assign fill_idx = fill_line_q[IDX_W-1:0];
	assign fill_word = (state_q == F_FILL) && mem_ack_i;

	// requested word arriving from the flash, also covers burst beats during a fill
	assign fill_hit = fill_word && rd_req && ({fill_line_q, fill_ofs_q} == req_waddr);

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= F_IDLE;
			valid_q <= '0;
			fill_ofs_q <= '0;
			cs_q <= 1'b0;
			burst_q <= 1'b0;
			ack_q <= 1'b0;
		end else begin
			ack_q <= bypass || buf_serve || fill_hit;
			case (state_q)
				F_IDLE: begin
					if (fill_start) begin
						state_q <= F_FILL;
						valid_q[req_idx] <= 1'b0;  // old line is being replaced
						fill_ofs_q <= '0;          // always from the line base
						cs_q <= 1'b1;
						burst_q <= 1'b0;
					end
				end
				F_FILL: begin
					if (mem_ack_i) begin
						if (fill_ofs_q == '1) begin
							state_q <= F_RESPOND;
							valid_q[fill_idx] <= 1'b1;
							cs_q <= 1'b0;
							burst_q <= 1'b0;
						end else begin
							fill_ofs_q <= fill_ofs_q + 1'b1;
							burst_q <= 1'b1;  // rest of the line in page mode
						end
					end
				end
				F_RESPOND: state_q <= F_IDLE;  // waiting request served from the new line
				default: state_q <= F_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (fill_start) begin
			fill_line_q <= req_waddr[ADDR_BITS-3:OFS_W];
			tag_q[req_idx] <= req_tag;
		end
		if (fill_word)
			buf_mem[{fill_idx, fill_ofs_q}] <= mem_dout_i;
		if (bypass)
			data_q <= '0;
		else if (buf_serve)
			data_q <= buf_mem[{req_idx, req_ofs}];
		else if (fill_hit)
			data_q <= mem_dout_i;
	end

	assign mem_req_o = '{cs: cs_q, burst: burst_q, addr: {fill_line_q, fill_ofs_q}};
	assign wbs_data_o = data_q;
	assign wbs_ack_o = ack_q;
	assign busy_o = (state_q != F_IDLE);

	// master holds stb until it sees ack
	a_ack_with_stb: assert property (@(posedge clk) disable iff (!rst_n_i)
		wbs_ack_o |-> (wb_i.cyc && wb_i.stb))
		else $error("wb_mem_adapter: ack without stb");

	a_cs_core_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
		$rose(mem_req_o.cs) |-> !mem_busy_i)
		else $error("wb_mem_adapter: fill started while core busy");

	// only linear incrementing bursts are supported
	a_linear_burst: assert property (@(posedge clk) disable iff (!rst_n_i)
		(wb_i.cyc && wb_i.stb && wb_i.cti == 3'b010) |-> (wb_i.bte == 2'b00))
		else $error("wb_mem_adapter: wrap burst requested");

endmodule

//--- flash_core.sv
`timescale 1ns/1ps
`include "flash_wb_defines.svh"

module flash_core #(
	parameter int CLK_FREQ = `FLASH_CLK_FREQ,  // MHz
	parameter int ADDR_BITS = `FLASH_ADDR_BITS,
	parameter int T_ACC_NS = `FLASH_T_ACC_NS,
	parameter int T_PAGE_NS = `FLASH_T_PAGE_NS
) (
	input  logic clk,
	input  logic rst_n_i,
	input  flash_wb_pkg::mem_req_t req_i,
	output flash_wb_pkg::half_t dout_o,
	output logic ack_o,
	output logic busy_o,
	output logic flash_ce_n_o,
	output logic flash_rst_n_o,
	output logic flash_oe_n_o,
	output logic flash_we_n_o,
	output logic flash_wp_n_o,
	input  logic flash_ready_i,
	output flash_wb_pkg::word_addr_t flash_addr_o,
	input  flash_wb_pkg::half_t flash_din_i
);
	import flash_wb_pkg::*;

	// access times rounded up to whole cycles
	localparam int ACC_CYC = (CLK_FREQ * T_ACC_NS + 999) / 1000;
	localparam int PAGE_CYC = (CLK_FREQ * T_PAGE_NS + 999) / 1000;
	localparam int MAX_CYC = (ACC_CYC > PAGE_CYC) ? ACC_CYC : PAGE_CYC;
	localparam int CNT_W = $clog2(MAX_CYC + 1);
	localparam int RST_W = $clog2(`FLASH_T_RST_CYC + 1);

	core_state_e state_q;
	logic [CNT_W-1:0] cnt_q;
	logic [RST_W-1:0] rst_cnt_q;
	logic [ADDR_BITS-3:0] addr_q;
	half_t dout_q;
	logic ack_q;
	logic in_access;
	logic start;
	logic sample;

	assign in_access = (state_q == C_ACCESS) || (state_q == C_PAGE);

	// no new access in the ack cycle since the adapter moves the address right after it
	assign start = (state_q == C_IDLE) && req_i.cs && !ack_q;
	assign sample = in_access && req_i.cs && (cnt_q == '0);

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= C_RESET;
			cnt_q <= '0;
			rst_cnt_q <= '0;
			ack_q <= 1'b0;
		end else begin
			ack_q <= 1'b0;
			case (state_q)
				C_RESET: begin
					if (rst_cnt_q == RST_W'(`FLASH_T_RST_CYC - 1))
						state_q <= C_WAIT_READY;
					else
						rst_cnt_q <= rst_cnt_q + 1'b1;
				end
				C_WAIT_READY: begin
					if (flash_ready_i)
						state_q <= C_IDLE;
				end
				C_IDLE: begin
					if (start) begin
						if (req_i.burst) begin
							state_q <= C_PAGE;
							cnt_q <= CNT_W'(PAGE_CYC - 1);
						end else begin
							state_q <= C_ACCESS;
							cnt_q <= CNT_W'(ACC_CYC - 1);
						end
					end
				end
				C_ACCESS, C_PAGE: begin
					if (!req_i.cs) begin
						state_q <= C_IDLE;  // dropped by the adapter
					end else if (sample) begin
						ack_q <= 1'b1;
						state_q <= C_IDLE;
					end else begin
						cnt_q <= cnt_q - 1'b1;
					end
				end
				default: state_q <= C_RESET;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start)
			addr_q <= req_i.addr;
		if (sample)
			dout_q <= flash_din_i;  // data settled after the full count
	end

	assign flash_rst_n_o = (state_q != C_RESET);
	assign flash_ce_n_o = !(req_i.cs && in_access);
	assign flash_oe_n_o = !(req_i.cs && in_access);
	assign flash_we_n_o = 1'b1;  // read only
	assign flash_wp_n_o = 1'b0;
	assign flash_addr_o = addr_q;

	assign dout_o = dout_q;
	assign ack_o = ack_q;
	assign busy_o = (state_q != C_IDLE);

	// data comes back only after the chip was enabled for at least a page time
	a_ack_after_ce: assert property (@(posedge clk) disable iff (!rst_n_i)
		$rose(ack_o) |-> ($past(!flash_ce_n_o) && $past(!flash_ce_n_o, PAGE_CYC)))
		else $error("flash_core: ack without chip enable");

	// the adapter must hold the address while the chip is working on it
	a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
		(in_access && req_i.cs) |-> (req_i.addr == addr_q))
		else $error("flash_core: address moved during access");

endmodule

//--- flash_wb_pkg.sv
`include "flash_wb_defines.svh"

package flash_wb_pkg;

	// device word address, byte address bits 24:2
	typedef logic [`FLASH_ADDR_BITS-3:0] word_addr_t;

	// wishbone word address, bits 31:2
	typedef logic [29:0] wb_addr_t;

	typedef logic [31:0] word_t;
	typedef logic [15:0] half_t;   // one chip

	// adapter to core request
	typedef struct packed {
		logic cs;          // held for a whole line
		logic burst;       // page word, not the first of the line
		word_addr_t addr;
	} mem_req_t;

	// shared and per-chip control pins
	typedef struct packed {
		logic [1:0] ce_n;
		logic rst_n;
		logic oe_n;
		logic we_n;
		logic wp_n;
	} flash_pins_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [2:0] cti;
		logic [1:0] bte;
		wb_addr_t addr;
	} wb_req_t;

	typedef enum logic [2:0] {C_RESET, C_WAIT_READY, C_IDLE, C_ACCESS, C_PAGE} core_state_e;

	typedef enum logic [1:0] {F_IDLE, F_FILL, F_RESPOND} fill_state_e;

endpackage

//--- flash_wb_defines.svh
`ifndef FLASH_WB_DEFINES_SVH
`define FLASH_WB_DEFINES_SVH

// main clock in MHz
`define FLASH_CLK_FREQ 100

// byte address width of the whole 32-bit device
`define FLASH_ADDR_BITS 25

// wishbone address bits 31:25 that select the flash region
`define FLASH_HIGH_ADDR 7'h7F

// one line / page is 16 bytes, 4 words
`define FLASH_BURST_BITS 4

// read buffer word address width, 16 words total
`define FLASH_BUF_BITS 4

// chip timing
`define FLASH_T_ACC_NS 100   // random access
`define FLASH_T_PAGE_NS 25   // access within an open page
`define FLASH_T_RST_CYC 8    // cycles rst_n is held low

`endif
